//--- csi_pkg.sv
package csi_pkg;

    localparam int WB_DATA_W = 32;

    // CSI-2 data type codes
    localparam logic [5:0] DT_FRAME_START = 6'h00;
    localparam logic [5:0] DT_FRAME_END   = 6'h01;
    localparam logic [5:0] DT_RAW10       = 6'h2B;

    localparam logic [1:0] REG_CONTROL     = 2'd0;
    localparam logic [1:0] REG_LINE_PIXELS = 2'd1;
    localparam logic [1:0] REG_FRAME_COUNT = 2'd2;

    localparam int RAW10_GROUP_PIXELS = 4;
    localparam int RAW10_GROUP_BYTES  = 5;

    localparam logic [15:0] CRC_POLY = 16'h8408; // ccitt, reflected
    localparam logic [15:0] CRC_SEED = 16'hFFFF;

    // header bits covered by each ecc parity bit
    localparam logic [23:0] ECC_MASK [0:5] = '{
        24'hF12CB7, 24'hF2555B, 24'h749A6D, 24'hB8E38E, 24'hDF03F0, 24'hEFFC00
    };

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_HEADER  = 2'd1;
    localparam logic [1:0] ST_PAYLOAD = 2'd2;
    localparam logic [1:0] ST_FOOTER  = 2'd3;

    // data identifier in the low byte, goes out first
    typedef union packed {
        struct packed {
            logic [15:0] frame_number;
            logic [7:0]  data_id;
        } short_pkt;
        struct packed {
            logic [15:0] word_count;
            logic [7:0]  data_id;
        } long_pkt;
    } packet_header_u;

endpackage

//--- csi_crc16.sv
`timescale 1ns/10ps
module csi_crc16 (
    input  logic        clock_camera_byte,
    input  logic        reset_camera_byte_n,
    input  logic        clear_i,
    input  logic        enable_i,
    input  logic [7:0]  data_i,
    output logic [15:0] crc_o
);
    import csi_pkg::*;

    logic [15:0] crc_next;

    // one byte, lsb first
    always_comb begin
        crc_next = crc_o;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ data_i[i]) begin
                crc_next = (crc_next >> 1) ^ CRC_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            crc_o <= CRC_SEED;
        end else if (clear_i) begin
            crc_o <= CRC_SEED; // start of each long packet
        end else if (enable_i) begin
            crc_o <= crc_next;
        end
    end

endmodule

//--- csi_config_regs.sv
`timescale 1ns/10ps
module csi_config_regs (
    input  logic                          clock_camera_byte,
    input  logic                          reset_camera_byte_n,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [1:0]                    wb_adr_i,
    input  logic [csi_pkg::WB_DATA_W-1:0] wb_dat_i,
    output logic [csi_pkg::WB_DATA_W-1:0] wb_dat_o,
    output logic                          wb_ack_o,
    input  logic                          frame_done_i,
    output logic                          enable_o,
    output logic [1:0]                    virtual_channel_o,
    output logic [15:0]                   line_pixels_o
);
    import csi_pkg::*;

    logic                 wb_req;
    logic                 wb_write;
    logic [WB_DATA_W-1:0] frame_count;

    assign wb_req   = wb_cyc_i & wb_stb_i & ~wb_ack_o; // new request only
    assign wb_write = wb_req & wb_we_i;

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_req;
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            enable_o          <= 1'b0;
            virtual_channel_o <= 2'd0;
            line_pixels_o     <= 16'd0;
        end else if (wb_write) begin
            case (wb_adr_i)
                REG_CONTROL: begin
                    enable_o          <= wb_dat_i[0];
                    virtual_channel_o <= wb_dat_i[2:1];
                end
                REG_LINE_PIXELS: line_pixels_o <= wb_dat_i[15:0];
                default: ; // frame count is read only
            endcase
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            frame_count <= '0;
        end else if (wb_write && wb_adr_i == REG_CONTROL) begin
            frame_count <= '0;
        end else if (frame_done_i) begin
            frame_count <= frame_count + 1'b1;
        end
    end

    // read data lands with ack
    always_ff @(posedge clock_camera_byte) begin
        if (wb_req && !wb_we_i) begin
            wb_dat_o <= '0;
            case (wb_adr_i)
                REG_CONTROL:     wb_dat_o[2:0]  <= {virtual_channel_o, enable_o};
                REG_LINE_PIXELS: wb_dat_o[15:0] <= line_pixels_o;
                REG_FRAME_COUNT: wb_dat_o       <= frame_count;
                default: ;
            endcase
        end
    end

endmodule

//--- raw10_byte_packer.sv
`timescale 1ns/10ps
module raw10_byte_packer (
    input  logic       clock_camera_byte,
    input  logic       reset_camera_byte_n,
    input  logic       enable_i,
    input  logic       line_valid_i,
    input  logic [9:0] pixel_data_i,
    output logic       pixel_ready_o,
    output logic [7:0] byte_data_o,
    output logic       byte_valid_o,
    input  logic       byte_ready_i
);
    import csi_pkg::*;

    logic [RAW10_GROUP_PIXELS-1:0][9:0] pix_q;
    logic [2:0]                         pix_cnt;
    logic [RAW10_GROUP_BYTES-1:0][7:0]  out_q;
    logic [2:0]                         byte_idx;
    logic                               coll_full;
    logic                               pix_take;
    logic                               byte_take;
    logic                               last_byte;
    logic                               group_move;

    assign coll_full  = (pix_cnt == RAW10_GROUP_PIXELS);
    assign last_byte  = (byte_idx == RAW10_GROUP_BYTES - 1);
    assign byte_take  = byte_valid_o & byte_ready_i;
    // output stage free now or after its last byte
    assign group_move = coll_full & (~byte_valid_o | (byte_take & last_byte));

    assign pixel_ready_o = enable_i & ~(coll_full & byte_valid_o); // stall when both full
    assign pix_take      = line_valid_i & pixel_ready_o;
    assign byte_data_o   = out_q[byte_idx];

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            pix_cnt <= 3'd0;
        end else if (group_move) begin
            pix_cnt <= {2'b00, pix_take}; // new pixel may start the next group
        end else if (pix_take) begin
            pix_cnt <= pix_cnt + 3'd1;
        end
    end

    // slot index wraps to zero while the group is full
    always_ff @(posedge clock_camera_byte) begin
        if (pix_take) begin
            pix_q[pix_cnt[1:0]] <= pixel_data_i;
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            byte_valid_o <= 1'b0;
            byte_idx     <= 3'd0;
        end else if (group_move) begin
            byte_valid_o <= 1'b1;
            byte_idx     <= 3'd0;
        end else if (byte_take) begin
            if (last_byte) begin
                byte_valid_o <= 1'b0;
            end else begin
                byte_idx <= byte_idx + 3'd1;
            end
        end
    end

    // msbs first, then the packed lsbs of all four
    always_ff @(posedge clock_camera_byte) begin
        if (group_move) begin
            for (int i = 0; i < RAW10_GROUP_PIXELS; i++) begin
                out_q[i]                               <= pix_q[i][9:2];
                out_q[RAW10_GROUP_BYTES-1][2*i +: 2]   <= pix_q[i][1:0];
            end
        end
    end

endmodule

//--- csi_packet_framer.sv
`timescale 1ns/10ps
module csi_packet_framer (
    input  logic        clock_camera_byte,
    input  logic        reset_camera_byte_n,
    input  logic        enable_i,
    input  logic [1:0]  virtual_channel_i,
    input  logic [15:0] line_pixels_i,
    input  logic        frame_valid_i,
    input  logic [7:0]  payload_data_i,
    input  logic        payload_valid_i,
    output logic        payload_ready_o,
    output logic [7:0]  byte_data_o,
    output logic        byte_valid_o,
    output logic        byte_last_o,
    input  logic        byte_ready_i,
    output logic        frame_done_o
);
    import csi_pkg::*;

    logic [1:0]     state;
    logic [1:0]     byte_idx;
    logic           fv_q;
    logic           fs_pend;
    logic           fe_pend;
    logic [15:0]    frame_num;
    logic [15:0]    pay_left;
    logic [15:0]    line_wc;
    packet_header_u hdr_q;
    logic [7:0]     ecc_byte;
    logic [31:0]    hdr_bytes;
    logic [15:0]    crc;
    logic           is_long;
    logic           out_take;
    logic           pay_take;
    logic           launch_fs;
    logic           launch_lp;
    logic           launch_fe;

    assign line_wc = 16'(line_pixels_i / RAW10_GROUP_PIXELS * RAW10_GROUP_BYTES);

    always_comb begin
        ecc_byte = 8'd0; // top two bits stay zero
        for (int i = 0; i < 6; i++) begin
            ecc_byte[i] = ^(hdr_q & ECC_MASK[i]);
        end
    end

    assign hdr_bytes = {ecc_byte, hdr_q};
    assign is_long   = (hdr_q.long_pkt.data_id[5:0] == DT_RAW10);

    // frame start first, then any line, frame end last
    assign launch_fs = (state == ST_IDLE) & fs_pend;
    assign launch_lp = (state == ST_IDLE) & ~fs_pend & payload_valid_i;
    assign launch_fe = (state == ST_IDLE) & ~fs_pend & ~payload_valid_i & fe_pend;

    always_comb begin
        byte_data_o  = payload_data_i;
        byte_valid_o = 1'b0;
        byte_last_o  = 1'b0;
        case (state)
            ST_HEADER: begin
                byte_data_o  = hdr_bytes[8*byte_idx +: 8];
                byte_valid_o = 1'b1;
                byte_last_o  = ~is_long & (byte_idx == 2'd3);
            end
            ST_PAYLOAD: byte_valid_o = payload_valid_i;
            ST_FOOTER: begin
                byte_data_o  = byte_idx[0] ? crc[15:8] : crc[7:0]; // low byte first
                byte_valid_o = 1'b1;
                byte_last_o  = byte_idx[0];
            end
            default: ;
        endcase
    end

    assign payload_ready_o = (state == ST_PAYLOAD) & byte_ready_i;
    assign out_take        = byte_valid_o & byte_ready_i;
    assign pay_take        = (state == ST_PAYLOAD) & out_take;
    assign frame_done_o    = out_take & byte_last_o & (state == ST_HEADER)
                           & (hdr_q.short_pkt.data_id[5:0] == DT_FRAME_END);

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            fv_q      <= 1'b0;
            fs_pend   <= 1'b0;
            fe_pend   <= 1'b0;
            frame_num <= 16'd0;
        end else begin
            fv_q <= frame_valid_i;
            if (!enable_i) begin
                fs_pend   <= 1'b0; // edges ignored while off
                fe_pend   <= 1'b0;
                frame_num <= 16'd0;
            end else begin
                if (launch_fs) begin
                    fs_pend   <= 1'b0;
                    frame_num <= frame_num + 16'd1;
                end
                if (launch_fe) fe_pend <= 1'b0;
                if (frame_valid_i && !fv_q) fs_pend <= 1'b1;
                if (!frame_valid_i && fv_q) fe_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            state    <= ST_IDLE;
            byte_idx <= 2'd0;
            pay_left <= 16'd0;
        end else begin
            case (state)
                ST_IDLE: begin
                    byte_idx <= 2'd0;
                    pay_left <= line_wc;
                    if (launch_fs || launch_lp || launch_fe) state <= ST_HEADER;
                end
                ST_HEADER: if (out_take) begin
                    byte_idx <= byte_idx + 2'd1; // wraps to zero after ecc
                    if (byte_idx == 2'd3) state <= is_long ? ST_PAYLOAD : ST_IDLE;
                end
                ST_PAYLOAD: if (pay_take) begin
                    pay_left <= pay_left - 16'd1;
                    if (pay_left == 16'd1) state <= ST_FOOTER;
                end
                default: if (out_take) begin
                    byte_idx <= byte_idx + 2'd1;
                    if (byte_idx[0]) state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock_camera_byte) begin
        if (launch_fs) begin
            hdr_q.short_pkt.data_id      <= {virtual_channel_i, DT_FRAME_START};
            hdr_q.short_pkt.frame_number <= frame_num + 16'd1;
        end else if (launch_fe) begin
            hdr_q.short_pkt.data_id      <= {virtual_channel_i, DT_FRAME_END};
            hdr_q.short_pkt.frame_number <= frame_num; // same as its frame start
        end else if (launch_lp) begin
            hdr_q.long_pkt.data_id    <= {virtual_channel_i, DT_RAW10};
            hdr_q.long_pkt.word_count <= line_wc;
        end
    end

    csi_crc16 crc16 (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .clear_i             (launch_lp),
        .enable_i            (pay_take),
        .data_i              (payload_data_i),
        .crc_o               (crc)
    );

endmodule

//--- csi_byte_tx_top.sv
`timescale 1ns/10ps
module csi_byte_tx_top (
    input  logic                          clock_camera_byte,
    input  logic                          reset_camera_byte_n,
    input  logic                          frame_valid_i,
    input  logic                          line_valid_i,
    input  logic [9:0]                    pixel_data_i,
    output logic                          pixel_ready_o,
    output logic [7:0]                    byte_data_o,
    output logic                          byte_valid_o,
    output logic                          byte_last_o,
    input  logic                          byte_ready_i,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [1:0]                    wb_adr_i,
    input  logic [csi_pkg::WB_DATA_W-1:0] wb_dat_i,
    output logic [csi_pkg::WB_DATA_W-1:0] wb_dat_o,
    output logic                          wb_ack_o
);

    logic        enable;
    logic [1:0]  virtual_channel;
    logic [15:0] line_pixels;
    logic        frame_done;
    logic [7:0]  payload_data;
    logic        payload_valid;
    logic        payload_ready;

    csi_config_regs regs (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .wb_cyc_i            (wb_cyc_i),
        .wb_stb_i            (wb_stb_i),
        .wb_we_i             (wb_we_i),
        .wb_adr_i            (wb_adr_i),
        .wb_dat_i            (wb_dat_i),
        .wb_dat_o            (wb_dat_o),
        .wb_ack_o            (wb_ack_o),
        .frame_done_i        (frame_done),
        .enable_o            (enable),
        .virtual_channel_o   (virtual_channel),
        .line_pixels_o       (line_pixels)
    );

    raw10_byte_packer packer (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .enable_i            (enable),
        .line_valid_i        (line_valid_i),
        .pixel_data_i        (pixel_data_i),
        .pixel_ready_o       (pixel_ready_o),
        .byte_data_o         (payload_data),
        .byte_valid_o        (payload_valid),
        .byte_ready_i        (payload_ready)
    );

    csi_packet_framer framer (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .enable_i            (enable),
        .virtual_channel_i   (virtual_channel),
        .line_pixels_i       (line_pixels),
        .frame_valid_i       (frame_valid_i),
        .payload_data_i      (payload_data),
        .payload_valid_i     (payload_valid),
        .payload_ready_o     (payload_ready),
        .byte_data_o         (byte_data_o),
        .byte_valid_o        (byte_valid_o),
        .byte_last_o         (byte_last_o),
        .byte_ready_i        (byte_ready_i),
        .frame_done_o        (frame_done)
    );

endmodule

//--- tb_csi_byte_tx.sv
`timescale 1ns/10ps
module tb_csi_byte_tx;
    import csi_pkg::*;

    localparam int LINE_PIX   = 16;
    localparam int NUM_LINES  = 6;  // lines over all tests
    localparam int LINE_BYTES = 4 + LINE_PIX * 5 / 4 + 2;
    localparam int CYCLE_LIMIT = NUM_LINES * (LINE_PIX + LINE_BYTES) * 4 + 3000;

    logic                 clock_camera_byte;
    logic                 reset_camera_byte_n;
    logic                 frame_valid_i, line_valid_i, byte_ready_i;
    logic [9:0]           pixel_data_i;
    logic                 pixel_ready_o, byte_valid_o, byte_last_o;
    logic [7:0]           byte_data_o;
    logic                 wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
    logic [1:0]           wb_adr_i;
    logic [WB_DATA_W-1:0] wb_dat_i, wb_dat_o;

    logic [8:0]  exp_q[$];  // {last, data}
    logic [8:0]  exp_byte;
    logic [31:0] seed = 32'h017440b4;
    logic        random_ready;
    int          errors, checks, bytes_seen, cycles, tests_run, tests_ok;
    logic [WB_DATA_W-1:0] rd_val;
    logic [9:0]  pixels [LINE_PIX];

    csi_byte_tx_top uut (.*);

    initial begin
        clock_camera_byte = 1'b0;
        forever #50 clock_camera_byte = ~clock_camera_byte;
    end

    function automatic logic [31:0] xorshift();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    // csi-2 ecc parity sets over the 24 header bits
    function automatic logic [7:0] header_ecc(input logic [23:0] hdr);
        logic [23:0] sets [6];
        logic [7:0]  ecc;
        sets = '{24'hF12CB7, 24'hF2555B, 24'h749A6D, 24'hB8E38E, 24'hDF03F0, 24'hEFFC00};
        ecc = 8'd0;
        for (int i = 0; i < 6; i++) ecc[i] = ^(hdr & sets[i]);
        return ecc;
    endfunction

    function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            if (crc[0] ^ b[i]) crc = (crc >> 1) ^ 16'h8408;
            else crc = crc >> 1;
        end
        return crc;
    endfunction

    task automatic expect_header(input logic [7:0] di, input logic [15:0] val, input logic lst);
        logic [23:0] hdr;
        hdr = {val, di};
        exp_q.push_back({1'b0, di});
        exp_q.push_back({1'b0, val[7:0]});
        exp_q.push_back({1'b0, val[15:8]});
        exp_q.push_back({lst, header_ecc(hdr)});
    endtask

    // expected long packet for the pixels held in the array
    task automatic expect_line(input logic [1:0] vc);
        logic [15:0] crc;
        logic [7:0]  b;
        crc = 16'hFFFF;
        expect_header({vc, DT_RAW10}, 16'(LINE_PIX * 5 / 4), 1'b0);
        for (int g = 0; g < LINE_PIX; g += 4) begin
            for (int k = 0; k < 5; k++) begin
                if (k < 4) b = pixels[g+k][9:2];
                else b = {pixels[g+3][1:0], pixels[g+2][1:0], pixels[g+1][1:0], pixels[g][1:0]};
                crc = crc_step(crc, b);
                exp_q.push_back({1'b0, b});
            end
        end
        exp_q.push_back({1'b0, crc[7:0]});
        exp_q.push_back({1'b1, crc[15:8]});
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] dat);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        @(posedge clock_camera_byte);
        assert (wb_ack_o == 1'b0) else begin
            $display("ack came back in the same cycle as the request");
            errors++;
        end
        @(posedge clock_camera_byte);
        assert (wb_ack_o == 1'b1) else begin
            $display("no ack one cycle after the request at address %0d", adr);
            errors++;
        end
        rd_val = wb_dat_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        @(posedge clock_camera_byte);
    endtask

    task automatic check_read(input logic [1:0] adr, input logic [31:0] want);
        wb_access(1'b0, adr, 32'd0);
        checks++;
        assert (rd_val == want) else begin
            $display("CHECK FAILED wb_dat_o got %h expected %h", rd_val, want);
            errors++;
        end
    endtask

    task automatic send_line(input logic gaps);
        for (int i = 0; i < LINE_PIX; i++) pixels[i] = xorshift() & 10'h3FF;
        expect_line(2'd2);
        for (int i = 0; i < LINE_PIX; i++) begin
            while (gaps && xorshift() % 3 == 0) begin
                line_valid_i <= 1'b0;
                @(posedge clock_camera_byte);
            end
            line_valid_i <= 1'b1;
            pixel_data_i <= pixels[i];
            @(posedge clock_camera_byte);
            while (!pixel_ready_o) @(posedge clock_camera_byte);
        end
        line_valid_i <= 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clock_camera_byte);
        repeat (4) @(posedge clock_camera_byte);
    endtask

    task automatic frame_edge(input logic fv, input logic [7:0] dt, input logic [15:0] fn);
        expect_header({2'd2, dt[5:0]}, fn, 1'b1);
        frame_valid_i <= fv;
        @(posedge clock_camera_byte);
        drain();
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) tests_ok++;
        $display("test %0d %s: %s", tests_run, name, errors == err_before ? "ok" : "failed");
    endtask

    // stream comparator
    always @(posedge clock_camera_byte) begin
        if (reset_camera_byte_n && byte_valid_o && byte_ready_i) begin
            bytes_seen++;
            assert (exp_q.size() != 0) else begin
                $display("byte %h sent when no byte was expected", byte_data_o);
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_byte = exp_q.pop_front();
                checks++;
                assert (byte_data_o == exp_byte[7:0]) else begin
                    $display("CHECK FAILED byte_data_o got %h expected %h", byte_data_o,
                             exp_byte[7:0]);
                    errors++;
                end
                assert (byte_last_o == exp_byte[8]) else begin
                    $display("CHECK FAILED byte_last_o got %h expected %h", byte_last_o,
                             exp_byte[8]);
                    errors++;
                end
            end
        end
    end

    always @(posedge clock_camera_byte) begin
        byte_ready_i <= random_ready ? xorshift() % 3 != 0 : 1'b1;
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int e;
        int seen;
        reset_camera_byte_n = 1'b0;
        frame_valid_i = 1'b0;
        line_valid_i  = 1'b0;
        pixel_data_i  = 10'd0;
        byte_ready_i  = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = 2'd0;
        wb_dat_i = '0;
        random_ready = 1'b0;
        repeat (16) @(posedge clock_camera_byte);
        reset_camera_byte_n <= 1'b1;
        @(posedge clock_camera_byte);

        e = errors;
        wb_access(1'b1, REG_LINE_PIXELS, LINE_PIX);
        wb_access(1'b1, REG_CONTROL, 32'h5); // enable, vc 2
        check_read(REG_CONTROL, 32'h5);
        check_read(REG_LINE_PIXELS, LINE_PIX);
        check_read(REG_FRAME_COUNT, 32'd0);
        finish_test("registers", e);

        e = errors;
        frame_edge(1'b1, DT_FRAME_START, 16'd1);
        finish_test("frame start", e);

        e = errors;
        send_line(1'b0);
        send_line(1'b0);
        drain();
        finish_test("long packets", e);

        e = errors;
        random_ready <= 1'b1;
        send_line(1'b1);
        send_line(1'b1);
        drain();
        random_ready <= 1'b0;
        finish_test("back-pressure", e);

        e = errors;
        frame_edge(1'b0, DT_FRAME_END, 16'd1);
        for (int f = 2; f <= 3; f++) begin
            frame_edge(1'b1, DT_FRAME_START, 16'(f));
            send_line(1'b0);
            drain();
            frame_edge(1'b0, DT_FRAME_END, 16'(f));
        end
        check_read(REG_FRAME_COUNT, 32'd3);
        wb_access(1'b1, REG_CONTROL, 32'h4); // disable
        check_read(REG_FRAME_COUNT, 32'd0); // cleared by the control write
        seen = bytes_seen;
        frame_valid_i <= 1'b1;
        repeat (20) @(posedge clock_camera_byte);
        frame_valid_i <= 1'b0;
        repeat (20) @(posedge clock_camera_byte);
        assert (bytes_seen == seen && !pixel_ready_o) else begin
            $display("bytes were sent or pixels accepted while disabled");
            errors++;
        end
        finish_test("frame end and counting", e);

        $display("tests %0d passed of %0d, checks %0d, errors %0d",
                 tests_ok, tests_run, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
csi_pkg.sv
csi_crc16.sv
csi_config_regs.sv
raw10_byte_packer.sv
csi_packet_framer.sv
csi_byte_tx_top.sv
tb_csi_byte_tx.sv

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_csi_byte_tx

out=$(./obj_dir/Vtb_csi_byte_tx)
echo "$out"

grep -q "RESULT: PASS" <<< "$out"
